//--- design/serial_bus_pkg.sv
package serial_bus_pkg;

    localparam int data_w     = 8;
    localparam int sel_w      = 2;
    localparam int offset_w   = 12;
    localparam int addr_w     = sel_w + offset_w;

    // select values 0 .. num_slaves-1 are mapped, the rest are dropped
    localparam int num_slaves = 3;

    // bytes per slave, one per offset value
    localparam int mem_depth  = 1 << offset_w;

    typedef struct packed {
        logic [sel_w-1:0]    sel;
        logic [offset_w-1:0] offset;
    } bus_addr_fields_t;

    // raw view goes out on the wire MSB first, fields view is decoded
    typedef union packed {
        logic [addr_w-1:0] raw;
        bus_addr_fields_t  fields;
    } bus_addr_u;

endpackage

//--- design/bus_master.sv
module bus_master
    import serial_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              write,
    input  bus_addr_u         addr,
    input  logic [data_w-1:0] wdata,
    input  logic              bus_grant,
    input  logic              rdata_bit,
    input  logic              rdata_valid,
    output logic              bus_req,
    output logic              addr_tx,
    output logic              addr_valid,
    output logic              write_tx,
    output logic              data_tx,
    output logic              data_valid,
    output logic              done,
    output logic [data_w-1:0] rdata
);

    typedef enum logic [2:0] {
        m_idle,
        m_req,
        m_addr,
        m_data,
        m_rwait,
        m_done
    } master_state_e;

    master_state_e     state;
    logic [3:0]        bit_cnt;
    logic              write_q;
    bus_addr_u         addr_sr;
    logic [data_w-1:0] wdata_sr;
    logic [data_w-1:0] rdata_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= m_idle;
            bit_cnt <= '0;
            write_q <= 1'b0;
        end else begin
            case (state)
                m_idle: begin
                    if (enable) begin
                        state   <= m_req;
                        write_q <= write;
                    end
                end
                m_req: begin
                    bit_cnt <= '0;
                    if (bus_grant)
                        state <= m_addr;
                end
                m_addr: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(addr_w - 1)) begin
                        bit_cnt <= '0;
                        state   <= write_q ? m_data : m_rwait;
                    end
                end
                m_data: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(data_w - 1))
                        state <= m_done;
                end
                m_rwait: begin
                    // wait for the slave, then count returned bits
                    if (rdata_valid) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'(data_w - 1))
                            state <= m_done;
                    end
                end
                default: state <= m_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && enable) begin
            addr_sr  <= addr;
            wdata_sr <= wdata;
        end else if (state == m_addr) begin
            addr_sr.raw <= {addr_sr.raw[addr_w-2:0], 1'b0};
        end else if (state == m_data) begin
            wdata_sr <= {wdata_sr[data_w-2:0], 1'b0};
        end
        if (state == m_rwait && rdata_valid)
            rdata_sr <= {rdata_sr[data_w-2:0], rdata_bit};
    end

    // request stays up through the done cycle
    assign bus_req    = state != m_idle;
    assign addr_tx    = addr_sr.raw[addr_w-1];
    assign addr_valid = state == m_addr;
    assign write_tx   = write_q;
    assign data_tx    = wdata_sr[data_w-1];
    assign data_valid = state == m_data;
    assign done       = state == m_done;
    assign rdata      = rdata_sr;

endmodule

//--- design/bus_slave.sv
module bus_slave
    import serial_bus_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic valid,
    input  logic write_en,
    input  logic addr_bit,
    input  logic data_bit,
    output logic data_out,
    output logic valid_out
);

    logic [4:0]          bit_cnt;
    logic                load;
    logic                sending;
    logic [2:0]          out_cnt;
    logic                mem_we;
    logic [offset_w-1:0] offset;
    logic [data_w-1:0]   wdata_sr;
    logic [data_w-1:0]   rdata_sr;
    logic [data_w-1:0]   mem [mem_depth] = '{default: '0};

    // last data bit of a write frame completes the byte
    assign mem_we = valid && write_en && bit_cnt == 5'(offset_w + data_w - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            load    <= 1'b0;
            sending <= 1'b0;
            out_cnt <= '0;
        end else begin
            load <= 1'b0;
            if (valid) begin
                bit_cnt <= bit_cnt + 5'd1;
                // a read frame ends with the offset
                if (!write_en && bit_cnt == 5'(offset_w - 1)) begin
                    bit_cnt <= '0;
                    load    <= 1'b1;
                end else if (mem_we) begin
                    bit_cnt <= '0;
                end
            end
            if (load) begin
                sending <= 1'b1;
                out_cnt <= '0;
            end else if (sending) begin
                out_cnt <= out_cnt + 3'd1;
                if (out_cnt == 3'(data_w - 1))
                    sending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid && bit_cnt < 5'(offset_w))
            offset <= {offset[offset_w-2:0], addr_bit};
        if (valid && bit_cnt >= 5'(offset_w))
            wdata_sr <= {wdata_sr[data_w-2:0], data_bit};
        if (mem_we)
            mem[offset] <= {wdata_sr[data_w-2:0], data_bit};
        if (load)
            rdata_sr <= mem[offset];
        else if (sending)
            rdata_sr <= {rdata_sr[data_w-2:0], 1'b0};
    end

    assign data_out  = rdata_sr[data_w-1];
    assign valid_out = sending;

endmodule

//--- design/bus_arbiter.sv
module bus_arbiter
    import serial_bus_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic m1_req,
    input  logic m1_addr_tx,
    input  logic m1_addr_valid,
    input  logic m1_write_tx,
    input  logic m1_data_tx,
    input  logic m1_data_valid,
    input  logic m2_req,
    input  logic m2_addr_tx,
    input  logic m2_addr_valid,
    input  logic m2_write_tx,
    input  logic m2_data_tx,
    input  logic m2_data_valid,
    input  logic s1_data_out,
    input  logic s1_valid_out,
    input  logic s2_data_out,
    input  logic s2_valid_out,
    input  logic s3_data_out,
    input  logic s3_valid_out,
    output logic m1_grant,
    output logic m1_rdata_bit,
    output logic m1_rdata_valid,
    output logic m2_grant,
    output logic m2_rdata_bit,
    output logic m2_rdata_valid,
    output logic s1_addr_bit,
    output logic s1_data_bit,
    output logic s1_valid,
    output logic s1_write_en,
    output logic s2_addr_bit,
    output logic s2_data_bit,
    output logic s2_valid,
    output logic s2_write_en,
    output logic s3_addr_bit,
    output logic s3_data_bit,
    output logic s3_valid,
    output logic s3_write_en
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_m1,
        arb_m2
    } arb_state_e;

    arb_state_e       state;
    logic             last_m2;
    logic [1:0]       sel_cnt;
    logic [sel_w-1:0] sel;
    logic             own_addr, own_addr_valid, own_write, own_data, own_data_valid;
    logic             fwd_valid, fwd_write, fwd_addr, fwd_data;
    logic             sl_bit, sl_valid;
    logic             ret_bit, ret_valid;
    logic [2:0]       hit;

    assign m1_grant = state == arb_m1;
    assign m2_grant = state == arb_m2;

    // a master that is not granted keeps its valids low
    assign own_addr       = m2_grant ? m2_addr_tx : m1_addr_tx;
    assign own_addr_valid = m2_grant ? m2_addr_valid : m1_addr_valid;
    assign own_write      = m2_grant ? m2_write_tx : m1_write_tx;
    assign own_data       = m2_grant ? m2_data_tx : m1_data_tx;
    assign own_data_valid = m2_grant ? m2_data_valid : m1_data_valid;

    always_comb begin
        case (sel)
            0: begin
                sl_bit   = s1_data_out;
                sl_valid = s1_valid_out;
            end
            1: begin
                sl_bit   = s2_data_out;
                sl_valid = s2_valid_out;
            end
            default: begin
                sl_bit   = s3_data_out;
                sl_valid = s3_valid_out;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= arb_idle;
            // m1 wins the first conflict after reset
            last_m2   <= 1'b1;
            sel_cnt   <= '0;
            sel       <= '0;
            fwd_valid <= 1'b0;
            fwd_write <= 1'b0;
            ret_valid <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    if (m1_req && (!m2_req || last_m2)) begin
                        state   <= arb_m1;
                        last_m2 <= 1'b0;
                    end else if (m2_req) begin
                        state   <= arb_m2;
                        last_m2 <= 1'b1;
                    end
                end
                arb_m1: if (!m1_req) state <= arb_idle;
                arb_m2: if (!m2_req) state <= arb_idle;
                default: state <= arb_idle;
            endcase
            // first address bits of the frame select the slave
            if (state == arb_idle) begin
                sel_cnt <= '0;
            end else if (own_addr_valid && sel_cnt < 2'(sel_w)) begin
                sel     <= {sel[sel_w-2:0], own_addr};
                sel_cnt <= sel_cnt + 2'd1;
            end
            fwd_valid <= (own_addr_valid && sel_cnt == 2'(sel_w)) || own_data_valid;
            fwd_write <= own_write;
            ret_valid <= sl_valid;
        end
    end

    always_ff @(posedge clk) begin
        fwd_addr <= own_addr;
        fwd_data <= own_data;
        ret_bit  <= sl_bit;
    end

    assign hit[0] = fwd_valid && sel == 0;
    assign hit[1] = fwd_valid && sel == 1;
    assign hit[2] = fwd_valid && sel == 2;

    assign s1_valid    = hit[0];
    assign s1_write_en = hit[0] && fwd_write;
    assign s1_addr_bit = hit[0] && fwd_addr;
    assign s1_data_bit = hit[0] && fwd_data;
    assign s2_valid    = hit[1];
    assign s2_write_en = hit[1] && fwd_write;
    assign s2_addr_bit = hit[1] && fwd_addr;
    assign s2_data_bit = hit[1] && fwd_data;
    assign s3_valid    = hit[2];
    assign s3_write_en = hit[2] && fwd_write;
    assign s3_addr_bit = hit[2] && fwd_addr;
    assign s3_data_bit = hit[2] && fwd_data;

    // read bits go back to whoever holds the grant
    assign m1_rdata_bit   = ret_bit;
    assign m1_rdata_valid = ret_valid && m1_grant;
    assign m2_rdata_bit   = ret_bit;
    assign m2_rdata_valid = ret_valid && m2_grant;

endmodule

//--- design/command_controller.sv
module command_controller
    import serial_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  logic              cmd_master,
    input  logic              cmd_write,
    input  bus_addr_u         cmd_addr,
    input  logic [data_w-1:0] cmd_wdata,
    input  logic              m1_done,
    input  logic              m2_done,
    output logic              cmd_drop,
    output logic              m1_enable,
    output logic              m1_write,
    output bus_addr_u         m1_addr,
    output logic [data_w-1:0] m1_wdata,
    output logic              m2_enable,
    output logic              m2_write,
    output bus_addr_u         m2_addr,
    output logic [data_w-1:0] m2_wdata
);

    logic [1:0]        full;
    logic [1:0]        enable;
    logic [1:0]        done;
    logic              accept;
    logic [1:0]        write_q;
    bus_addr_u         addr_q  [2];
    logic [data_w-1:0] wdata_q [2];

    assign done = {m2_done, m1_done};

    // a slot is free again in the cycle its done arrives
    assign accept = cmd_valid && cmd_addr.fields.sel < num_slaves
                    && !(full[cmd_master] && !done[cmd_master]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full     <= '0;
            enable   <= '0;
            cmd_drop <= 1'b0;
        end else begin
            cmd_drop <= cmd_valid && !accept;
            for (int i = 0; i < 2; i++) begin
                enable[i] <= accept && cmd_master == 1'(i);
                if (accept && cmd_master == 1'(i))
                    full[i] <= 1'b1;
                else if (done[i])
                    full[i] <= 1'b0;
            end
        end
    end

    // held until the master reports done
    always_ff @(posedge clk) begin
        if (accept) begin
            write_q[cmd_master] <= cmd_write;
            addr_q[cmd_master]  <= cmd_addr;
            wdata_q[cmd_master] <= cmd_wdata;
        end
    end

    assign m1_enable = enable[0];
    assign m1_write  = write_q[0];
    assign m1_addr   = addr_q[0];
    assign m1_wdata  = wdata_q[0];
    assign m2_enable = enable[1];
    assign m2_write  = write_q[1];
    assign m2_addr   = addr_q[1];
    assign m2_wdata  = wdata_q[1];

endmodule

//--- design/serial_bus_top.sv
module serial_bus_top
    import serial_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  logic              cmd_master,
    input  logic              cmd_write,
    input  logic [addr_w-1:0] cmd_addr,
    input  logic [data_w-1:0] cmd_wdata,
    output logic              cmd_drop,
    output logic              m1_done,
    output logic [data_w-1:0] m1_rdata,
    output logic              m2_done,
    output logic [data_w-1:0] m2_rdata
);

    // controller to masters
    logic              m1_enable, m1_write, m2_enable, m2_write;
    bus_addr_u         m1_addr, m2_addr;
    logic [data_w-1:0] m1_wdata, m2_wdata;

    // master frame lines and arbiter returns
    logic m1_req, m1_addr_tx, m1_addr_valid, m1_write_tx, m1_data_tx, m1_data_valid;
    logic m2_req, m2_addr_tx, m2_addr_valid, m2_write_tx, m2_data_tx, m2_data_valid;
    logic m1_grant, m1_rdata_bit, m1_rdata_valid;
    logic m2_grant, m2_rdata_bit, m2_rdata_valid;

    // arbiter to slaves and back
    logic s1_addr_bit, s1_data_bit, s1_valid, s1_write_en, s1_data_out, s1_valid_out;
    logic s2_addr_bit, s2_data_bit, s2_valid, s2_write_en, s2_data_out, s2_valid_out;
    logic s3_addr_bit, s3_data_bit, s3_valid, s3_write_en, s3_data_out, s3_valid_out;

    command_controller controller (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_master(cmd_master), .cmd_write(cmd_write),
        .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .m1_done(m1_done), .m2_done(m2_done), .cmd_drop(cmd_drop),
        .m1_enable(m1_enable), .m1_write(m1_write), .m1_addr(m1_addr), .m1_wdata(m1_wdata),
        .m2_enable(m2_enable), .m2_write(m2_write), .m2_addr(m2_addr), .m2_wdata(m2_wdata)
    );

    bus_master master1 (
        .clk(clk), .rst_n(rst_n),
        .enable(m1_enable), .write(m1_write), .addr(m1_addr), .wdata(m1_wdata),
        .bus_grant(m1_grant), .rdata_bit(m1_rdata_bit), .rdata_valid(m1_rdata_valid),
        .bus_req(m1_req), .addr_tx(m1_addr_tx), .addr_valid(m1_addr_valid),
        .write_tx(m1_write_tx), .data_tx(m1_data_tx), .data_valid(m1_data_valid),
        .done(m1_done), .rdata(m1_rdata)
    );

    bus_master master2 (
        .clk(clk), .rst_n(rst_n),
        .enable(m2_enable), .write(m2_write), .addr(m2_addr), .wdata(m2_wdata),
        .bus_grant(m2_grant), .rdata_bit(m2_rdata_bit), .rdata_valid(m2_rdata_valid),
        .bus_req(m2_req), .addr_tx(m2_addr_tx), .addr_valid(m2_addr_valid),
        .write_tx(m2_write_tx), .data_tx(m2_data_tx), .data_valid(m2_data_valid),
        .done(m2_done), .rdata(m2_rdata)
    );

    bus_arbiter arbiter (
        .clk(clk), .rst_n(rst_n),
        .m1_req(m1_req), .m1_addr_tx(m1_addr_tx), .m1_addr_valid(m1_addr_valid),
        .m1_write_tx(m1_write_tx), .m1_data_tx(m1_data_tx), .m1_data_valid(m1_data_valid),
        .m2_req(m2_req), .m2_addr_tx(m2_addr_tx), .m2_addr_valid(m2_addr_valid),
        .m2_write_tx(m2_write_tx), .m2_data_tx(m2_data_tx), .m2_data_valid(m2_data_valid),
        .s1_data_out(s1_data_out), .s1_valid_out(s1_valid_out),
        .s2_data_out(s2_data_out), .s2_valid_out(s2_valid_out),
        .s3_data_out(s3_data_out), .s3_valid_out(s3_valid_out),
        .m1_grant(m1_grant), .m1_rdata_bit(m1_rdata_bit), .m1_rdata_valid(m1_rdata_valid),
        .m2_grant(m2_grant), .m2_rdata_bit(m2_rdata_bit), .m2_rdata_valid(m2_rdata_valid),
        .s1_addr_bit(s1_addr_bit), .s1_data_bit(s1_data_bit),
        .s1_valid(s1_valid), .s1_write_en(s1_write_en),
        .s2_addr_bit(s2_addr_bit), .s2_data_bit(s2_data_bit),
        .s2_valid(s2_valid), .s2_write_en(s2_write_en),
        .s3_addr_bit(s3_addr_bit), .s3_data_bit(s3_data_bit),
        .s3_valid(s3_valid), .s3_write_en(s3_write_en)
    );

    bus_slave slave1 (
        .clk(clk), .rst_n(rst_n), .valid(s1_valid), .write_en(s1_write_en),
        .addr_bit(s1_addr_bit), .data_bit(s1_data_bit),
        .data_out(s1_data_out), .valid_out(s1_valid_out)
    );

    bus_slave slave2 (
        .clk(clk), .rst_n(rst_n), .valid(s2_valid), .write_en(s2_write_en),
        .addr_bit(s2_addr_bit), .data_bit(s2_data_bit),
        .data_out(s2_data_out), .valid_out(s2_valid_out)
    );

    bus_slave slave3 (
        .clk(clk), .rst_n(rst_n), .valid(s3_valid), .write_en(s3_write_en),
        .addr_bit(s3_addr_bit), .data_bit(s3_data_bit),
        .data_out(s3_data_out), .valid_out(s3_valid_out)
    );

endmodule

//--- tb/serial_bus_checker.sv
module serial_bus_checker
    import serial_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  logic              cmd_master,
    input  logic              cmd_write,
    input  logic [addr_w-1:0] cmd_addr,
    input  logic [data_w-1:0] cmd_wdata,
    input  logic              cmd_drop,
    input  logic              m1_done,
    input  logic [data_w-1:0] m1_rdata,
    input  logic              m2_done,
    input  logic [data_w-1:0] m2_rdata,
    input  int                test_num,
    output int                pass_count,
    output int                fail_count
);

    localparam int               entry_w      = 1 + addr_w + data_w;
    localparam logic [sel_w-1:0] unmapped_sel = 2'd3;

    // accepted commands per master, oldest first: write, address, data
    logic [entry_w-1:0] m1_q [$];
    logic [entry_w-1:0] m2_q [$];
    logic [data_w-1:0]  ref_mem [logic [addr_w-1:0]];
    logic               drop_expected = 1'b0;
    int                 next_owner = 0;
    int                 cur_test = 0;
    int                 pass_at_start = 0;
    int                 fail_at_start = 0;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // reference memory of all three slaves, unwritten bytes are zero
    function automatic logic [data_w-1:0] expected_read(input logic [addr_w-1:0] addr);
        if (ref_mem.exists(addr))
            return ref_mem[addr];
        return '0;
    endfunction

    task automatic log_command();
        logic busy;
        busy = cmd_master ? m2_q.size() != 0 : m1_q.size() != 0;
        if (cmd_addr[addr_w-1 -: sel_w] == unmapped_sel || busy)
            drop_expected = 1'b1;
        else if (cmd_master)
            m2_q.push_back({cmd_write, cmd_addr, cmd_wdata});
        else
            m1_q.push_back({cmd_write, cmd_addr, cmd_wdata});
    endtask

    task automatic retire_command(input int m, input logic [data_w-1:0] rdata);
        logic [entry_w-1:0] entry;
        logic [data_w-1:0]  expected;
        if (next_owner != 0 && next_owner != m) begin
            $display("** Error at %0t: bus owner expected master %0d, got master %0d",
                     $time, next_owner, m);
            fail_count++;
        end
        if ((m == 1 && m1_q.size() == 0) || (m == 2 && m2_q.size() == 0)) begin
            $display("master %0d signalled done at %0t with no command pending", m, $time);
            fail_count++;
            return;
        end
        if (m == 1)
            entry = m1_q.pop_front();
        else
            entry = m2_q.pop_front();
        if (entry[entry_w-1]) begin
            ref_mem[entry[data_w +: addr_w]] = entry[data_w-1:0];
        end else begin
            expected = expected_read(entry[data_w +: addr_w]);
            if (rdata !== expected) begin
                $display("** Error at %0t: m%0d_rdata expected 0x%02h, got 0x%02h",
                         $time, m, expected, rdata);
                fail_count++;
            end else begin
                pass_count++;
            end
        end
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            if (fail_count == fail_at_start)
                $display("test %0d passed, %0d checks", cur_test, pass_count - pass_at_start);
            else
                $display("test %0d failed, %0d errors", cur_test, fail_count - fail_at_start);
        end
        if (test_num == 0 && (m1_q.size() != 0 || m2_q.size() != 0)) begin
            $display("commands were still pending when the run ended");
            fail_count++;
        end
        cur_test      = test_num;
        pass_at_start = pass_count;
        fail_at_start = fail_count;
    endtask

    // inputs and outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (cmd_drop !== drop_expected) begin
                $display("** Error at %0t: cmd_drop expected %0b, got %0b",
                         $time, drop_expected, cmd_drop);
                fail_count++;
            end else if (drop_expected) begin
                pass_count++;
            end
            drop_expected = 1'b0;
            if (m1_done)
                retire_command(1, m1_rdata);
            if (m2_done)
                retire_command(2, m2_rdata);
            if (cmd_valid)
                log_command();
            // a master left waiting gets the bus next
            if (m1_done)
                next_owner = m2_q.size() != 0 ? 2 : 0;
            if (m2_done)
                next_owner = m1_q.size() != 0 ? 1 : 0;
            if (test_num != cur_test)
                close_test();
        end
    end

endmodule

//--- tb/serial_bus_tb.sv
module serial_bus_tb
    import serial_bus_pkg::*;
();

    localparam int          clk_period     = 20;
    localparam int          mem_depth      = 4096;
    localparam int          offset_bits    = $clog2(mem_depth);
    localparam logic [31:0] seed           = 32'haa52_b0c7;
    localparam int          num_cmds       = 58;
    localparam int          cycles_per_cmd = 200;

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    logic              cmd_master;
    logic              cmd_write;
    logic [addr_w-1:0] cmd_addr;
    logic [data_w-1:0] cmd_wdata;
    logic              cmd_drop;
    logic              m1_done;
    logic [data_w-1:0] m1_rdata;
    logic              m2_done;
    logic [data_w-1:0] m2_rdata;
    logic [31:0]       lfsr;
    int                test_num;
    int                pass_count;
    int                fail_count;

    serial_bus_top dut (
        .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_master(cmd_master),
        .cmd_write(cmd_write), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .cmd_drop(cmd_drop), .m1_done(m1_done), .m1_rdata(m1_rdata),
        .m2_done(m2_done), .m2_rdata(m2_rdata)
    );

    serial_bus_checker scoreboard (
        .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_master(cmd_master),
        .cmd_write(cmd_write), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
        .cmd_drop(cmd_drop), .m1_done(m1_done), .m1_rdata(m1_rdata),
        .m2_done(m2_done), .m2_rdata(m2_rdata), .test_num(test_num),
        .pass_count(pass_count), .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // holds the strobe for one cycle from 2 units after a rising edge
    task automatic issue(input logic master, input logic write,
                         input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
        cmd_valid  = 1'b1;
        cmd_master = master;
        cmd_write  = write;
        cmd_addr   = addr;
        cmd_wdata  = wdata;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_done(input logic master);
        do begin
            @(posedge clk);
            #2;
        end while (!(master ? m2_done : m1_done));
    endtask

    initial begin
        repeat (num_cmds * cycles_per_cmd) @(posedge clk);
        $display("timeout after %0d cycles, a transfer never completed",
                 num_cmds * cycles_per_cmd);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0]       r;
        logic [addr_w-1:0] a1, a2, a3;
        logic [sel_w-1:0]  sel;
        logic              m, w;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_master = 1'b0;
        cmd_write  = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        test_num   = 0;
        lfsr       = seed;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // write then read back once in every slave
        test_num = 1;
        for (int s = 0; s < 3; s++) begin
            draw(offset_bits, r);
            a1 = {2'(s), r[offset_bits-1:0]};
            draw(data_w, r);
            issue(1'b0, 1'b1, a1, r[data_w-1:0]);
            wait_done(1'b0);
            issue(1'b0, 1'b0, a1, '0);
            wait_done(1'b0);
        end

        test_num = 2;
        draw(offset_bits, r);
        issue(1'b1, 1'b0, {2'd1, r[offset_bits-1:0]}, '0);
        wait_done(1'b1);

        // m2 waits behind m1 and m1 asks again in its done cycle
        test_num = 3;
        draw(offset_bits, r);
        a1 = {2'd0, r[offset_bits-1:0]};
        draw(offset_bits, r);
        a2 = {2'd1, r[offset_bits-1:0]};
        draw(offset_bits, r);
        a3 = {2'd2, r[offset_bits-1:0]};
        draw(data_w, r);
        issue(1'b0, 1'b1, a1, r[data_w-1:0]);
        draw(data_w, r);
        issue(1'b1, 1'b1, a2, r[data_w-1:0]);
        wait_done(1'b0);
        issue(1'b0, 1'b0, a1, '0);
        wait_done(1'b1);
        wait_done(1'b0);
        issue(1'b1, 1'b0, a2, '0);
        wait_done(1'b1);
        // last write to the shared byte comes from the master granted last
        draw(data_w, r);
        issue(1'b0, 1'b1, a3, r[data_w-1:0]);
        draw(data_w, r);
        issue(1'b1, 1'b1, a3, r[data_w-1:0]);
        wait_done(1'b0);
        draw(data_w, r);
        issue(1'b0, 1'b1, a3, r[data_w-1:0]);
        wait_done(1'b1);
        wait_done(1'b0);
        issue(1'b1, 1'b0, a3, '0);
        wait_done(1'b1);

        test_num = 4;
        draw(offset_bits + data_w, r);
        issue(1'b0, 1'b1, {2'd3, r[offset_bits+data_w-1:data_w]}, r[data_w-1:0]);
        repeat (40) @(posedge clk);
        #2;

        test_num = 5;
        issue(1'b1, 1'b0, a1, '0);
        draw(data_w, r);
        issue(1'b1, 1'b1, a2, r[data_w-1:0]);
        wait_done(1'b1);

        // narrow offsets so reads land on earlier writes
        test_num = 6;
        for (int i = 0; i < 40; i++) begin
            draw(1, r);
            m = r[0];
            draw(1, r);
            w = r[0];
            draw(sel_w, r);
            sel = r[sel_w-1:0] % 2'd3;
            draw(4 + data_w, r);
            issue(m, w, {sel, 8'h00, r[data_w+3:data_w]}, r[data_w-1:0]);
            wait_done(m);
        end

        test_num = 0;
        repeat (2) @(posedge clk);
        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- serial_bus_top.f
design/serial_bus_pkg.sv
design/bus_master.sv
design/bus_slave.sv
design/bus_arbiter.sv
design/command_controller.sv
design/serial_bus_top.sv
tb/serial_bus_checker.sv
tb/serial_bus_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = serial_bus_tb
FILELIST  = serial_bus_top.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf $(OBJ_DIR)
